//--- hdl/cla_adder32.sv
/*
  32-bit carry-lookahead adder, 4-bit groups with a second lookahead level.
  No carry-in, the adder always starts from zero.
  carry_out is the carry out of the top group.
*/
`timescale 1ns/1ps
`default_nettype none

module cla_adder32 import mul_pkg::*; (
   input  prod_t x,
   input  prod_t y,
   output prod_t sum,
   output logic  carry_out
);

   prod_t                 p;       // bit propagate
   prod_t                 g;       // bit generate
   logic [CLA_GROUPS-1:0] grp_p;
   logic [CLA_GROUPS-1:0] grp_g;
   logic [CLA_GROUPS:0]   grp_c;   // carry into each group

   // carry into position n, flattened to sum of products
   function automatic logic lookahead(input logic [CLA_GROUPS-1:0] gv,
                                      input logic [CLA_GROUPS-1:0] pv,
                                      input logic                  cin,
                                      input int                    n);
      logic c;
      logic term;
      c = cin;
      for (int k = 0; k < CLA_GROUPS; k++) begin
         if (k < n)
            c = c & pv[k];
      end
      for (int m = 0; m < CLA_GROUPS; m++) begin
         term = gv[m] && (m < n);
         for (int k = m + 1; k < CLA_GROUPS; k++) begin
            if (k < n)
               term = term & pv[k];
         end
         c = c | term;
      end
      return c;
   endfunction

   assign p = x ^ y;
   assign g = x & y;

   for (genvar k = 0; k < CLA_GROUPS; k++) begin : g_grp
      logic [CLA_GROUPS-1:0] gs;   // group slice, zero padded
      logic [CLA_GROUPS-1:0] ps;

      assign gs       = CLA_GROUPS'(g[k*CLA_GROUP_W +: CLA_GROUP_W]);
      assign ps       = CLA_GROUPS'(p[k*CLA_GROUP_W +: CLA_GROUP_W]);
      assign grp_p[k] = &p[k*CLA_GROUP_W +: CLA_GROUP_W];
      assign grp_g[k] = lookahead(gs, ps, 1'b0, CLA_GROUP_W);

      // local lookahead from the group carry-in
      for (genvar j = 0; j < CLA_GROUP_W; j++) begin : g_bit
         assign sum[k*CLA_GROUP_W+j] = p[k*CLA_GROUP_W+j] ^ lookahead(gs, ps, grp_c[k], j);
      end
   end

   // second level over the group terms
   for (genvar k = 0; k <= CLA_GROUPS; k++) begin : g_gc
      assign grp_c[k] = lookahead(grp_g, grp_p, 1'b0, k);
   end

   assign carry_out = grp_c[CLA_GROUPS];

endmodule

`default_nettype wire

//--- hdl/mul16_top.sv
/*
  16x16 unsigned multiplier with a four-phase req/ack handshake.
  Exact 32-bit product, built from four 8x8 quadrants.
  a and b must stay stable while req is high.
  Latency is two clock edges from the first edge that samples req high.
*/
`timescale 1ns/1ps
`default_nettype none

module mul16_top import mul_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  req,
   input  op_t   a,
   input  op_t   b,
   output logic  ack,
   output prod_t product
);

   mul_data_if dp_if ();   // operand bytes and raw product

   mul_handshake_ctrl u_ctrl (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .a       (a),
      .b       (b),
      .ack     (ack),
      .product (product),
      .dp      (dp_if.ctrl)
   );

   // combinational, read back by the control in CALC
   product_combiner u_comb (
      .dp (dp_if.datapath)
   );

endmodule

`default_nettype wire

//--- hdl/mul_data_if.sv
/*
  Operand bytes and product between the handshake control and the datapath.
  prod is combinational from the registered bytes.
  No handshake of its own, the control FSM decides when prod is taken.
*/
`timescale 1ns/1ps
`default_nettype none

interface mul_data_if import mul_pkg::*; ();

   half_t a_hi;
   half_t a_lo;
   half_t b_hi;
   half_t b_lo;
   prod_t prod;   // settles within the CALC cycle

   // control side registers the bytes and samples the product
   modport ctrl (
      output a_hi, a_lo, b_hi, b_lo,
      input  prod
   );

   modport datapath (
      input  a_hi, a_lo, b_hi, b_lo,
      output prod
   );

endinterface

`default_nettype wire

//--- hdl/mul_handshake_ctrl.sv
/*
  Four-phase req/ack control around the multiplier datapath.
  The requester must hold a and b stable while req is high.
  ack rises two edges after req is first sampled high, and drops on the
  first edge that sees req low. One transaction at a time.
  product is zero after reset and holds until the next result.
*/
`timescale 1ns/1ps
`default_nettype none

module mul_handshake_ctrl import mul_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req,
   input  op_t         a,
   input  op_t         b,
   output logic        ack,
   output prod_t       product,
   mul_data_if.ctrl    dp
);

   mul_state_e state;
   mul_state_e state_nxt;
   logic       capture;   // new operands taken this edge

   assign capture = (state == IDLE) && req;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (req) state_nxt = CALC;
         CALC:    state_nxt = DONE;            // product settles in one cycle
         DONE:    if (!req) state_nxt = IDLE;  // back-pressure holds us here
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= IDLE;
      else
         state <= state_nxt;
   end

   // operand bytes feed the datapath directly
   always_ff @(posedge clk) begin
      if (capture) begin
         dp.a_hi <= a[FULL_W-1:HALF_W];
         dp.a_lo <= a[HALF_W-1:0];
         dp.b_hi <= b[FULL_W-1:HALF_W];
         dp.b_lo <= b[HALF_W-1:0];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         product <= '0;
      else if (state == CALC)
         product <= dp.prod;
   end

   assign ack = (state == DONE);

   // ack only answers a pending request
   a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> $past(req));

   a_product_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (ack && $past(ack)) |-> $stable(product));

   a_idle_holds: assert property (@(posedge clk) disable iff (!rst_n)
      (state == IDLE && !req) |=> (state == IDLE));

endmodule

`default_nettype wire

//--- hdl/mul_pkg.sv
/*
  Widths and types shared by the 16x16 unsigned multiplier.
  The byte split assumes FULL_W is exactly twice HALF_W.
  The adder assumes PROD_W equals CLA_GROUPS * CLA_GROUP_W.
*/
`default_nettype none

package mul_pkg;

   localparam int HALF_W      = 8;            // one operand byte
   localparam int FULL_W      = 2 * HALF_W;   // operand width
   localparam int PROD_W      = 2 * FULL_W;   // full product width
   localparam int CLA_GROUP_W = 4;            // bits per lookahead group
   localparam int CLA_GROUPS  = PROD_W / CLA_GROUP_W;

   typedef logic [HALF_W-1:0]   half_t;
   typedef logic [FULL_W-1:0]   op_t;
   typedef logic [2*HALF_W-1:0] quad_t;   // one 8x8 quadrant product
   typedef logic [PROD_W-1:0]   prod_t;

   // handshake control states
   typedef enum logic [1:0] {
      IDLE,   // waiting for req
      CALC,   // operands held, product settling
      DONE    // ack high until req drops
   } mul_state_e;

endpackage

`default_nettype wire

//--- hdl/product_combiner.sv
/*
  Datapath of the multiplier, combinational with zero latency.
  Four quadrant products, cross terms moved up one byte, two adder stages.
  An exact product always fits 32 bits, so the last carry is never set.
*/
`timescale 1ns/1ps
`default_nettype none

module product_combiner import mul_pkg::*; (
   mul_data_if.datapath dp
);

   quad_t ll;
   quad_t lh;
   quad_t hl;
   quad_t hh;
   prod_t llhh;       // hh:ll, no overlap
   prod_t lh_sh;
   prod_t hl_sh;
   prod_t stage1;
   logic  carry2;

   quad_mult8 u_ll (.x(dp.a_lo), .y(dp.b_lo), .p(ll));
   quad_mult8 u_lh (.x(dp.a_lo), .y(dp.b_hi), .p(lh));
   quad_mult8 u_hl (.x(dp.a_hi), .y(dp.b_lo), .p(hl));
   quad_mult8 u_hh (.x(dp.a_hi), .y(dp.b_hi), .p(hh));

   assign llhh  = {hh, ll};
   assign lh_sh = {{HALF_W{1'b0}}, lh, {HALF_W{1'b0}}};   // weight 2^8
   assign hl_sh = {{HALF_W{1'b0}}, hl, {HALF_W{1'b0}}};

   // first stage carry cannot be set either
   cla_adder32 u_add1 (.x(llhh), .y(lh_sh), .sum(stage1), .carry_out());
   cla_adder32 u_add2 (.x(stage1), .y(hl_sh), .sum(dp.prod), .carry_out(carry2));

   a_no_overflow: assert final ($isunknown({dp.a_hi, dp.a_lo, dp.b_hi, dp.b_lo}) || !carry2)
      else $error("product overflowed 32 bits, lookahead reduction is broken");

endmodule

`default_nettype wire

//--- hdl/quad_mult8.sv
/*
  Exact 8x8 unsigned array multiplier for one quadrant.
  Purely combinational, the depth grows with HALF_W rows of ripple adders.
*/
`timescale 1ns/1ps
`default_nettype none

module quad_mult8 import mul_pkg::*; (
   input  half_t x,
   input  half_t y,
   output quad_t p
);

   logic [HALF_W-1:0] pp [HALF_W];    // partial product rows
   logic [HALF_W-1:0] acc [HALF_W];   // running sum after each row
   logic [HALF_W:0]   cy [HALF_W];    // ripple carries per row

   for (genvar r = 0; r < HALF_W; r++) begin : g_pp
      assign pp[r] = x & {HALF_W{y[r]}};
   end

   // first row passes straight through
   assign acc[0] = pp[0];
   assign cy[0]  = '0;

   for (genvar i = 1; i < HALF_W; i++) begin : g_row
      assign cy[i][0] = 1'b0;

      for (genvar j = 0; j < HALF_W; j++) begin : g_fa
         logic a_in;     // previous row, moved down one weight
         logic half_s;

         if (j == HALF_W - 1) begin : g_top
            assign a_in = cy[i-1][HALF_W];   // carry out of the row above
         end else begin : g_mid
            assign a_in = acc[i-1][j+1];
         end

         assign half_s      = a_in ^ pp[i][j];
         assign acc[i][j]   = half_s ^ cy[i][j];
         assign cy[i][j+1]  = (a_in & pp[i][j]) | (half_s & cy[i][j]);
      end

      // lowest bit of each finished row is final
      assign p[i-1] = acc[i-1][0];
   end

   assign p[2*HALF_W-1:HALF_W-1] = {cy[HALF_W-1][HALF_W], acc[HALF_W-1]};

endmodule

`default_nettype wire

//--- src.f
hdl/mul_pkg.sv
hdl/mul_data_if.sv
hdl/quad_mult8.sv
hdl/cla_adder32.sv
hdl/product_combiner.sv
hdl/mul_handshake_ctrl.sv
hdl/mul16_top.sv
tb/mul16_checker.sv
tb/tb_mul16.sv

//--- tb/mul16_checker.sv
/*
  Watches the multiplier ports, checks every result and handshake step.
  Operands are taken at the edge that first samples req high.
  Assumes one transaction at a time, as the four-phase rule requires.
  Outputs are sampled at the rising edge, before the DUT updates them.
*/
`timescale 1ns/1ps
`default_nettype none

module mul16_checker import mul_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  req,
   input  op_t   a,
   input  op_t   b,
   input  logic  ack,
   input  prod_t product,
   input  int    test_id,
   output int    mismatch_errs,
   output int    proto_errs,
   output int    checked
);

   logic  req_q = 1'b0;
   logic  ack_q = 1'b0;
   logic  busy = 1'b0;          // between capture and ack fall
   logic  have_result = 1'b0;   // product zero until the first result
   int    edges = 0;            // edges since capture
   op_t   a_cap;
   op_t   b_cap;

   initial begin
      mismatch_errs = 0;
      proto_errs    = 0;
      checked       = 0;
   end

   // exact unsigned product of the two operands
   function automatic prod_t ref_product(input op_t x, input op_t y);
      return prod_t'(x) * prod_t'(y);
   endfunction

   function automatic string test_name(input int id);
      case (id)
         0:       return "reset";
         1:       return "corner";
         2:       return "random";
         3:       return "backpressure";
         default: return "back_to_back";
      endcase
   endfunction

   task automatic report_mismatch(input prod_t expected, input prod_t actual);
      mismatch_errs++;
      $display("Mismatch test=%s expected=%h actual=%h", test_name(test_id), expected, actual);
   endtask

   task automatic report_violation(input string what);
      proto_errs++;
      $display("Error at %0t in test %s: %s", $time, test_name(test_id), what);
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         if (ack !== 1'b0)
            report_violation("ack is high during reset");
         if (product !== '0)
            report_mismatch('0, product);
         busy        = 1'b0;
         have_result = 1'b0;
         req_q       = 1'b0;
         ack_q       = 1'b0;
      end else begin
         if (busy)
            edges++;
         if (ack && !ack_q) begin
            if (!busy || edges != 2)
               report_violation($sformatf("ack rose %0d edges after req, not 2", edges));
            checked++;
            if (product !== ref_product(a_cap, b_cap))
               report_mismatch(ref_product(a_cap, b_cap), product);
            have_result = 1'b1;
         end else if (busy && !ack && edges == 2) begin
            report_violation("ack did not rise two edges after req");
            busy = 1'b0;
         end
         if (ack && ack_q && product !== ref_product(a_cap, b_cap))
            report_mismatch(ref_product(a_cap, b_cap), product);   // must hold while ack is high
         if (ack_q && req_q && !ack)
            report_violation("ack dropped while req was still high");
         if (ack_q && !req_q && ack)
            report_violation("ack stayed high after an edge saw req low");
         if (ack_q && !ack)
            busy = 1'b0;
         if (busy && !ack && !req)
            report_violation("req dropped before ack rose");
         if (!have_result && product !== '0)
            report_mismatch('0, product);
         if (req && !req_q && !busy) begin
            a_cap = a;
            b_cap = b;
            busy  = 1'b1;
            edges = 0;
         end
         req_q = req;
         ack_q = ack;
      end
   end

endmodule

`default_nettype wire

//--- tb/tb_mul16.sv
/*
  Testbench for the 16x16 multiplier with the four-phase handshake.
  Inputs change 1 ns after the rising edge, the checker does the comparing.
  Random operands and hold lengths repeat from a fixed seed.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mul16 import mul_pkg::*; ();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 8;
   localparam int MAX_HOLD     = 10;   // extra req cycles after ack
   localparam int N_CORNER     = 25;
   localparam int N_RANDOM     = 200;
   localparam int N_HOLD       = 40;
   localparam int N_B2B        = 20;
   localparam int N_TXN        = N_CORNER + N_RANDOM + N_HOLD + N_B2B;

   logic   clk;
   logic   rst_n;
   logic   req;
   op_t    a;
   op_t    b;
   logic   ack;
   prod_t  product;
   int     test_id;
   int     mismatch_errs;
   int     proto_errs;
   int     checked;
   int     other_errs = 0;
   integer seed;
   op_t    corners [5] = '{16'h0000, 16'h0001, 16'h00ff, 16'hff00, 16'hffff};

   mul16_top u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .a       (a),
      .b       (b),
      .ack     (ack),
      .product (product)
   );

   mul16_checker u_chk (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .a             (a),
      .b             (b),
      .ack           (ack),
      .product       (product),
      .test_id       (test_id),
      .mismatch_errs (mismatch_errs),
      .proto_errs    (proto_errs),
      .checked       (checked)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic wait_ack(input logic level);
      while (ack !== level) begin
         @(posedge clk);
         #1;
      end
   endtask

   // one four-phase transaction, operands optionally scrambled after ack
   task automatic run_txn(input op_t x, input op_t y, input int hold, input bit scramble);
      a   = x;
      b   = y;
      req = 1'b1;
      wait_ack(1'b1);
      repeat (hold) begin
         @(posedge clk);
         #1;
         if (scramble) begin
            a = op_t'($random(seed));
            b = op_t'($random(seed));
         end
      end
      req = 1'b0;
      wait_ack(1'b0);
   endtask

   initial begin
      op_t x;
      op_t y;
      int  hold;
      seed    = 32'hcb19;
      rst_n   = 1'b0;
      req     = 1'b0;
      a       = '0;
      b       = '0;
      test_id = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
      repeat (3) @(posedge clk);   // idle, product must stay zero
      #1;
      test_id = 1;
      foreach (corners[i])
         foreach (corners[j])
            run_txn(corners[i], corners[j], 0, 1'b0);
      test_id = 2;
      repeat (N_RANDOM) begin
         x = op_t'($random(seed));
         y = op_t'($random(seed));
         run_txn(x, y, 0, 1'b0);
      end
      test_id = 3;
      repeat (N_HOLD) begin
         x    = op_t'($random(seed));
         y    = op_t'($random(seed));
         hold = $unsigned($random(seed)) % (MAX_HOLD + 1);
         run_txn(x, y, hold, 1'b1);
      end
      test_id = 4;
      for (int i = 0; i < N_B2B; i++) begin
         x = (i % 2 == 0) ? 16'hffff : op_t'($random(seed));   // full product, then small
         y = (i % 2 == 0) ? 16'hffff : op_t'($random(seed));
         run_txn(x, y, 0, 1'b0);
      end
      repeat (2) @(posedge clk);
      if (checked != N_TXN) begin
         other_errs++;
         $display("Error: %0d results checked for %0d transactions", checked, N_TXN);
      end
      $display("errors: %0d mismatch, %0d handshake, %0d other",
               mismatch_errs, proto_errs, other_errs);
      if (mismatch_errs + proto_errs + other_errs == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // worst case per transaction is MAX_HOLD plus a few handshake edges
   initial begin
      #((RESET_CYCLES + N_TXN * (MAX_HOLD + 6)) * CLK_PERIOD);
      $display("Timeout: the handshake stalled before all transactions finished");
      $display("errors: %0d mismatch, %0d handshake, %0d other",
               mismatch_errs, proto_errs, other_errs);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire
